//--- src/leaf_params.svh
`ifndef LEAF_PARAMS_SVH
`define LEAF_PARAMS_SVH

// user side word width and port counts
`define LEAF_PAYLOAD_BITS   32
`define LEAF_NUM_IN_PORTS   2
`define LEAF_NUM_OUT_PORTS  2
// input fifo depth, kept a power of two
`define LEAF_FIFO_DEPTH     4
// packet port number that maps onto user input port 0
`define LEAF_FIRST_IN_PORT  2

// bft packet field widths
`define LEAF_LEAF_BITS      4
`define LEAF_PORT_BITS      4
`define LEAF_ADDR_BITS      7
`define LEAF_OUT_IDX_BITS   1
`define LEAF_PACKET_BITS    48

`endif

//--- src/leaf_pkg.sv
`include "leaf_params.svh"

package leaf_pkg;

    // route view of a configuration payload
    typedef struct packed {
        logic [`LEAF_OUT_IDX_BITS-1:0] out_idx;
        logic [`LEAF_LEAF_BITS-1:0]    dest_leaf;
        logic [`LEAF_PORT_BITS-1:0]    dest_port;
        logic [`LEAF_ADDR_BITS-1:0]    base_addr;
        // unused upper part of the word
        logic [`LEAF_PAYLOAD_BITS-`LEAF_OUT_IDX_BITS-`LEAF_LEAF_BITS
               -`LEAF_PORT_BITS-`LEAF_ADDR_BITS-1:0] spare;
    } route_word_t;

    // same word is user data on ports 2/3 and a route on port 0
    typedef union packed {
        logic [`LEAF_PAYLOAD_BITS-1:0] data;
        route_word_t                   route;
    } payload_u;

    // one flit on the tree link, msb first
    typedef struct packed {
        logic                       valid;
        logic [`LEAF_LEAF_BITS-1:0] leaf;
        logic [`LEAF_PORT_BITS-1:0] port;
        logic [`LEAF_ADDR_BITS-1:0] addr;
        payload_u                   payload;
    } bft_packet_t;

    // stored route of one output port
    typedef struct packed {
        logic [`LEAF_LEAF_BITS-1:0] dest_leaf;
        logic [`LEAF_PORT_BITS-1:0] dest_port;
        logic [`LEAF_ADDR_BITS-1:0] base_addr;
    } route_t;

    // reserved packet port numbers
    localparam logic [`LEAF_PORT_BITS-1:0] CFG_PORT = `LEAF_PORT_BITS'(0);
    localparam logic [`LEAF_PORT_BITS-1:0] RSV_PORT = `LEAF_PORT_BITS'(1);

endpackage

//--- src/leaf_cfg_if.sv
`timescale 1ns/10ps
`include "leaf_params.svh"

// route write from the extractor into the route registers
// one cycle strobe, no back-pressure
interface leaf_cfg_if;
    logic                          wr;
    logic [`LEAF_OUT_IDX_BITS-1:0] out_idx;
    logic [`LEAF_LEAF_BITS-1:0]    dest_leaf;
    logic [`LEAF_PORT_BITS-1:0]    dest_port;
    logic [`LEAF_ADDR_BITS-1:0]    base_addr;

    // extractor side
    modport src (output wr, output out_idx, output dest_leaf, output dest_port,
                 output base_addr);

    // route register side
    modport dst (input wr, input out_idx, input dest_leaf, input dest_port,
                 input base_addr);
endinterface

//--- src/extract_control.sv
`timescale 1ns/10ps
`include "leaf_params.svh"

module extract_control (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [`LEAF_PACKET_BITS-1:0] din,
    output logic [`LEAF_PACKET_BITS-1:0] dout,
    input  logic                         resend,
    output leaf_pkg::bft_packet_t        to_user,
    input  leaf_pkg::bft_packet_t        from_user,
    output logic                         slot_free,
    leaf_cfg_if.src                      cfg
);
    import leaf_pkg::*;

    // registered tree input
    bft_packet_t in_q;
    // registered outgoing packet
    bft_packet_t out_q;
    // last valid packet sent, kept for replay
    bft_packet_t last_q;
    logic        is_cfg;
    logic        is_rsv;

    // input register, reset clears the valid flag
    always_ff @(posedge clk) begin
        in_q <= din;
        if (reset) begin
            in_q.valid <= 1'b0;
        end
    end

    // port decode on the registered flit
    assign is_cfg = (in_q.port == CFG_PORT);
    assign is_rsv = (in_q.port == RSV_PORT);

    // port 0 turns into a route write, read through the route view
    assign cfg.wr        = in_q.valid && is_cfg;
    assign cfg.out_idx   = in_q.payload.route.out_idx;
    assign cfg.dest_leaf = in_q.payload.route.dest_leaf;
    assign cfg.dest_port = in_q.payload.route.dest_port;
    assign cfg.base_addr = in_q.payload.route.base_addr;

    // everything else except the reserved port goes to the fifos
    always_comb begin
        to_user       = in_q;
        to_user.valid = in_q.valid && !is_cfg && !is_rsv;
    end

    // no new word may be granted while the tree asks for a replay
    assign slot_free = !resend;

    // outgoing register, one cycle after the user accept
    always_ff @(posedge clk) begin
        out_q <= from_user;
        if (from_user.valid) begin
            last_q <= from_user;
        end
        if (reset) begin
            out_q.valid  <= 1'b0;
            last_q.valid <= 1'b0;
        end
    end

    // replay the held packet for as long as resend stays high
    // after it drops out_q is invalid until the next accept
    assign dout = resend ? last_q : out_q;

endmodule

//--- src/config_controls.sv
`timescale 1ns/10ps
`include "leaf_params.svh"

module config_controls (
    input  logic            clk,
    input  logic            reset,
    leaf_cfg_if.dst         cfg,
    output leaf_pkg::route_t routes [`LEAF_NUM_OUT_PORTS]
);
    import leaf_pkg::*;

    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;

    // route carried by the current write
    route_t wr_route;

    always_comb begin
        wr_route.dest_leaf = cfg.dest_leaf;
        wr_route.dest_port = cfg.dest_port;
        wr_route.base_addr = cfg.base_addr;
    end

    // one register per output port
    // all routes zero after reset, so packets head to leaf 0 port 0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < NUM_OUT; p++) begin
                routes[p] <= '0;
            end
        end else if (cfg.wr) begin
            // updated route is seen by the packer next cycle
            routes[cfg.out_idx] <= wr_route;
        end
    end

endmodule

//--- src/stream_flow_control.sv
`timescale 1ns/10ps
`include "leaf_params.svh"

module stream_flow_control (
    input  logic                                                clk,
    input  logic                                                reset,
    input  leaf_pkg::bft_packet_t                               to_user,
    output leaf_pkg::bft_packet_t                               from_user,
    input  logic                                                slot_free,
    input  leaf_pkg::route_t                                    routes [`LEAF_NUM_OUT_PORTS],
    output logic [`LEAF_PAYLOAD_BITS*`LEAF_NUM_IN_PORTS-1:0]    user_dout,
    output logic [`LEAF_NUM_IN_PORTS-1:0]                       user_vld,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]                       user_ack,
    input  logic [`LEAF_PAYLOAD_BITS*`LEAF_NUM_OUT_PORTS-1:0]   user_din,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]                      user_vld_in,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]                      user_ack_out
);
    import leaf_pkg::*;

    localparam int W       = `LEAF_PAYLOAD_BITS;
    localparam int NUM_IN  = `LEAF_NUM_IN_PORTS;
    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;
    localparam int DEPTH   = `LEAF_FIFO_DEPTH;
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CNT_W   = $clog2(DEPTH + 1);
    localparam int PORT_W  = `LEAF_PORT_BITS;
    localparam int ADDR_W  = `LEAF_ADDR_BITS;
    localparam int GNT_W   = (NUM_OUT > 1) ? $clog2(NUM_OUT) : 1;

    // fifo index of the arriving flit
    logic [PORT_W-1:0] in_sel;

    assign in_sel = to_user.port - PORT_W'(`LEAF_FIRST_IN_PORT);

    // input side, one circular fifo per user input port
    for (genvar i = 0; i < NUM_IN; i++) begin : g_in
        logic [W-1:0]     mem [DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             push;
        logic             pop;

        // a full fifo simply loses the flit
        assign push = to_user.valid && (in_sel == PORT_W'(i)) && (count != CNT_W'(DEPTH));
        assign pop  = user_vld[i] && user_ack[i];

        // head word is shown whenever the fifo holds something
        assign user_vld[i]          = (count != '0);
        assign user_dout[i*W +: W] = mem[rd_ptr];

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= to_user.payload.data;
            end
        end

        // pointers wrap on their own since depth is a power of two
        always_ff @(posedge clk) begin
            if (reset) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                wr_ptr <= wr_ptr + PTR_W'(push);
                rd_ptr <= rd_ptr + PTR_W'(pop);
                count  <= count + CNT_W'(push) - CNT_W'(pop);
            end
        end
    end

    // output side, round robin over requesting ports
    logic [NUM_OUT-1:0] req;
    logic [NUM_OUT-1:0] grant;
    logic [GNT_W-1:0]   gnt_idx;
    logic [GNT_W-1:0]   last_gnt;
    logic               found;
    int                 idx;
    logic [ADDR_W-1:0]  eff_addr [NUM_OUT];

    // nobody is served while a replay is running
    assign req = user_vld_in & {NUM_OUT{slot_free}};

    // search starts just after the last winner
    always_comb begin
        grant   = '0;
        gnt_idx = last_gnt;
        found   = 1'b0;
        idx     = 0;
        for (int k = 1; k <= NUM_OUT; k++) begin
            idx = (int'(last_gnt) + k) % NUM_OUT;
            if (!found && req[idx]) begin
                grant[idx] = 1'b1;
                gnt_idx    = GNT_W'(idx);
                found      = 1'b1;
            end
        end
    end

    // ack straight from the grant
    assign user_ack_out = grant;

    // port 0 wins the first contest after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            last_gnt <= GNT_W'(NUM_OUT - 1);
        end else if (found) begin
            last_gnt <= gnt_idx;
        end
    end

    // per port running address
    for (genvar p = 0; p < NUM_OUT; p++) begin : g_out
        route_t            route_q;
        logic [ADDR_W-1:0] addr_cnt;
        logic              route_chg;

        // a rewritten route shows up as a change against last cycle
        assign route_chg   = (routes[p] != route_q);
        // fresh base address is used at once, even in the reload cycle
        assign eff_addr[p] = route_chg ? routes[p].base_addr : addr_cnt;

        // 7 bit address wraps naturally
        always_ff @(posedge clk) begin
            if (reset) begin
                route_q  <= '0;
                addr_cnt <= '0;
            end else begin
                route_q  <= routes[p];
                addr_cnt <= eff_addr[p] + ADDR_W'(grant[p]);
            end
        end
    end

    // wrap the granted word with its route
    always_comb begin
        from_user       = '0;
        from_user.valid = found;
        for (int p = 0; p < NUM_OUT; p++) begin
            if (grant[p]) begin
                from_user.leaf         = routes[p].dest_leaf;
                from_user.port         = routes[p].dest_port;
                from_user.addr         = eff_addr[p];
                from_user.payload.data = user_din[p*W +: W];
            end
        end
    end

endmodule

//--- src/leaf_interface.sv
`timescale 1ns/10ps
`include "leaf_params.svh"

module leaf_interface (
    input  logic                                              clk,
    input  logic                                              reset,
    // tree link in
    input  logic [`LEAF_PACKET_BITS-1:0]                      din_leaf_bft2interface,
    // tree link out
    output logic [`LEAF_PACKET_BITS-1:0]                      dout_leaf_interface2bft,
    input  logic                                              resend,
    // words toward the user block
    output logic [`LEAF_PAYLOAD_BITS*`LEAF_NUM_IN_PORTS-1:0]  dout_leaf_interface2user,
    output logic [`LEAF_NUM_IN_PORTS-1:0]                     vld_interface2user,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]                     ack_user2interface,
    // words from the user block
    output logic [`LEAF_NUM_OUT_PORTS-1:0]                    ack_interface2user,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]                    vld_user2interface,
    input  logic [`LEAF_PAYLOAD_BITS*`LEAF_NUM_OUT_PORTS-1:0] din_leaf_user2interface
);
    import leaf_pkg::*;

    // extractor to fifos
    bft_packet_t to_user;
    // packer to extractor
    bft_packet_t from_user;
    logic        slot_free;
    route_t      routes [`LEAF_NUM_OUT_PORTS];

    leaf_cfg_if cfg ();

    extract_control ex_ctrl (
        .clk       (clk),
        .reset     (reset),
        .din       (din_leaf_bft2interface),
        .dout      (dout_leaf_interface2bft),
        .resend    (resend),
        .to_user   (to_user),
        .from_user (from_user),
        .slot_free (slot_free),
        .cfg       (cfg.src)
    );

    config_controls con_ctrl (
        .clk    (clk),
        .reset  (reset),
        .cfg    (cfg.dst),
        .routes (routes)
    );

    stream_flow_control sfc (
        .clk          (clk),
        .reset        (reset),
        .to_user      (to_user),
        .from_user    (from_user),
        .slot_free    (slot_free),
        .routes       (routes),
        .user_dout    (dout_leaf_interface2user),
        .user_vld     (vld_interface2user),
        .user_ack     (ack_user2interface),
        .user_din     (din_leaf_user2interface),
        .user_vld_in  (vld_user2interface),
        .user_ack_out (ack_interface2user)
    );

endmodule

//--- tb/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);
    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held over the first edges, released with the other tb inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
    end
endmodule

//--- tb/leaf_props.sv
`timescale 1ns/10ps
`include "leaf_params.svh"

module leaf_props (
    input logic                           clk,
    input logic                           reset,
    input logic                           resend,
    input logic [`LEAF_NUM_IN_PORTS-1:0]  vld_interface2user,
    input logic [`LEAF_NUM_IN_PORTS-1:0]  ack_user2interface,
    input logic [`LEAF_NUM_OUT_PORTS-1:0] ack_interface2user
);
    // a word shown to the user stays until it is taken
    for (genvar i = 0; i < `LEAF_NUM_IN_PORTS; i++) begin : g_vld
        a_vld_held: assert property (@(posedge clk) disable iff (reset)
            vld_interface2user[i] && !ack_user2interface[i] |=> vld_interface2user[i])
            else $error("vld_interface2user[%0d] dropped before ack", i);
    end

    // replay means back-pressure on every output port
    a_no_ack_in_resend: assert property (@(posedge clk) disable iff (reset)
        resend |-> (ack_interface2user == '0))
        else $error("ack_interface2user high while resend is high");

    // one word onto the tree per cycle
    a_single_ack: assert property (@(posedge clk) disable iff (reset)
        $onehot0(ack_interface2user))
        else $error("more than one ack_interface2user in one cycle");
endmodule

bind leaf_interface leaf_props u_props (
    .clk                (clk),
    .reset              (reset),
    .resend             (resend),
    .vld_interface2user (vld_interface2user),
    .ack_user2interface (ack_user2interface),
    .ack_interface2user (ack_interface2user)
);

//--- tb/leaf_tb.sv
`timescale 1ns/10ps
`include "leaf_params.svh"

module leaf_tb;
    localparam int W       = `LEAF_PAYLOAD_BITS;
    localparam int PKT_W   = `LEAF_PACKET_BITS;
    localparam int NUM_IN  = `LEAF_NUM_IN_PORTS;
    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;
    localparam int MAX_REC = 128;

    logic                     clk;
    logic                     reset;
    logic [PKT_W-1:0]         din_leaf_bft2interface;
    logic [PKT_W-1:0]         dout_leaf_interface2bft;
    logic                     resend;
    logic [W*NUM_IN-1:0]      dout_leaf_interface2user;
    logic [NUM_IN-1:0]        vld_interface2user;
    logic [NUM_IN-1:0]        ack_user2interface;
    logic [NUM_OUT-1:0]       ack_interface2user;
    logic [NUM_OUT-1:0]       vld_user2interface;
    logic [W*NUM_OUT-1:0]     din_leaf_user2interface;

    // record is kind, port or count, then one 48 bit packet
    logic [PKT_W+7:0] golden [MAX_REC];
    int               num_rec;
    int               limit = 0;
    int               cycles = 0;
    // scoreboards
    logic [PKT_W-1:0] exp_out [NUM_OUT][$];
    logic [W-1:0]     exp_in [NUM_IN][$];
    logic [W-1:0]     tx_q [NUM_OUT][$];
    int               src_q [$];
    // handshake state seen at the last falling edge
    logic [NUM_OUT-1:0] taken = '0;
    logic [NUM_OUT-1:0] last_ack = '0;
    logic               last_both = 1'b0;
    logic [PKT_W-1:0]   last_pkt = '0;

    clk_gen #(.PERIOD(40), .RESET_CYCLES(3)) u_clk (.clk(clk), .reset(reset));

    leaf_interface u_dut (.*);

    task automatic fail_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    // one flit on the tree link for a single edge
    task automatic inject(input logic [PKT_W-1:0] pkt);
        @(posedge clk);
        #2 din_leaf_bft2interface = pkt;
        @(posedge clk);
        #2 din_leaf_bft2interface = '0;
    endtask

    task automatic resend_window(input int len);
        @(posedge clk);
        #2 resend = 1'b1;
        repeat (len) @(posedge clk);
        #2 resend = 1'b0;
    endtask

    function automatic int outstanding();
        int n;
        n = 0;
        for (int p = 0; p < NUM_OUT; p++) n += exp_out[p].size();
        for (int i = 0; i < NUM_IN; i++) n += exp_in[i].size();
        return n;
    endfunction

    task automatic wait_drained();
        while (outstanding() != 0) @(negedge clk);
    endtask

    initial begin
        int               idx;
        logic [3:0]       kind;
        logic [PKT_W-1:0] pkt;
        void'($urandom(40));
        din_leaf_bft2interface  = '0;
        resend                  = 1'b0;
        ack_user2interface      = '0;
        vld_user2interface      = '0;
        din_leaf_user2interface = '0;
        for (int r = 0; r < MAX_REC; r++) golden[r] = '0;
        $readmemh("tb/leaf_golden.txt", golden);
        num_rec = 0;
        while (num_rec < MAX_REC && golden[num_rec][PKT_W+7:PKT_W+4] != 4'h0) num_rec++;
        limit = 50 * num_rec + 200;
        // quiet link and user ports after reset
        wait (reset == 1'b0);
        repeat (3) begin
            @(negedge clk);
            check_value("reset dout valid", 0, dout_leaf_interface2bft[PKT_W-1]);
            check_value("reset vld", 0, vld_interface2user);
        end
        for (int r = 0; r < num_rec; r++) begin
            kind = golden[r][PKT_W+7:PKT_W+4];
            idx  = int'(golden[r][PKT_W+3:PKT_W]);
            pkt  = golden[r][PKT_W-1:0];
            case (kind)
                4'h1: inject(pkt);
                4'h2: begin
                    tx_q[idx].push_back(pkt[W-1:0]);
                    exp_out[idx].push_back(pkt);
                end
                4'h3: resend_window(idx);
                4'h4: exp_in[idx].push_back(pkt[W-1:0]);
                4'h5: repeat (idx) @(posedge clk);
                4'h6: wait_drained();
                default: begin
                    $display("golden record %0d has an unknown kind %h", r, kind);
                    fail_run();
                end
            endcase
        end
        wait_drained();
        // let stray words show up before judging
        repeat (5) @(negedge clk);
        // nothing may be left waiting at the user input ports
        check_value("input words left after the run", 0, vld_interface2user);
        if (src_q.size() == 0 && tx_q[0].size() == 0 && tx_q[1].size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("user words were accepted but never left on the tree link");
            fail_run();
        end
    end

    // user output words, shown 2 ns after the edge, dropped once taken
    always @(posedge clk) begin
        #2;
        for (int p = 0; p < NUM_OUT; p++) begin
            if (taken[p]) void'(tx_q[p].pop_front());
            vld_user2interface[p]          = (tx_q[p].size() != 0);
            din_leaf_user2interface[p*W +: W] = (tx_q[p].size() != 0) ? tx_q[p][0] : '0;
        end
        ack_user2interface = NUM_IN'($urandom);
    end

    // monitors run mid cycle where every signal is settled
    always @(negedge clk) begin
        logic [PKT_W-1:0] pkt;
        int               src;
        logic             both;
        if (!reset) begin
            pkt = dout_leaf_interface2bft;
            // a new packet, replays of the held one are skipped
            if (pkt[PKT_W-1] && (!resend || pkt != last_pkt)) begin
                if (src_q.size() == 0) begin
                    $display("packet %h left on the tree with no word accepted", pkt);
                    fail_run();
                end
                src = src_q.pop_front();
                check_value($sformatf("outgoing packet of port %0d", src),
                            exp_out[src].pop_front(), pkt);
                last_pkt = pkt;
            end
            if (resend) begin
                if (last_pkt[PKT_W-1]) check_value("resend replay", last_pkt, pkt);
                check_value("ack during resend", 0, ack_interface2user);
            end
            taken = vld_user2interface & ack_interface2user;
            for (int p = 0; p < NUM_OUT; p++) begin
                if (taken[p]) src_q.push_back(p);
            end
            // round robin must alternate while both ports wait
            both = &vld_user2interface;
            if (both && last_both && taken != '0 && taken == last_ack) begin
                $display("output port granted twice in a row while the other waited");
                fail_run();
            end
            last_both = both;
            last_ack  = taken;
            // words delivered to the user block
            for (int i = 0; i < NUM_IN; i++) begin
                if (vld_interface2user[i] && ack_user2interface[i]) begin
                    if (exp_in[i].size() == 0) begin
                        $display("word %h reached user port %0d with nothing expected",
                                 dout_leaf_interface2user[i*W +: W], i);
                        fail_run();
                    end
                    check_value($sformatf("input word of port %0d", i),
                                exp_in[i].pop_front(), dout_leaf_interface2user[i*W +: W]);
                end
            end
        end
    end

    // run limit scales with the golden file
    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            fail_run();
        end
    end
endmodule

//--- tb/leaf_golden.txt
// columns: kind(1) port or count(1) packet(12) = valid leaf port addr payload
// kinds: 1 inject, 2 user word+expected, 3 resend, 4 expected input, 5 idle, 6 drain, 0 end
// routes: out 0 to leaf 5 port 3 base 7e, out 1 to leaf 9 port 2 base 10
10800029FE0000
108000C9100000
52000000000000
// port 0 alone, address wraps past 7f
20A9FE11110001
20A9FF11110002
20A98011110003
60000000000000
// both ports loaded at once
20A98122220001
21C91033330001
20A98222220002
21C91133330002
20A98322220003
21C91233330003
60000000000000
// resend right after an accept
20A98444440001
21C91355550001
20A98544440002
51000000000000
34000000000000
60000000000000
// expected user input words
400000AAAA0001
400000AAAA0002
400000AAAA0003
400000AAAA0004
410000BBBB0001
410000BBBB0002
410000BBBB0003
// tree packets, reserved and config ones mixed in
108900AAAA0001
108980BBBB0001
108880DEADBEEF
108900AAAA0002
10800029FE0000
108980BBBB0002
108900AAAA0003
108980BBBB0003
108900AAAA0004
60000000000000
00000000000000

//--- sim.f
+incdir+src
src/leaf_pkg.sv
src/leaf_cfg_if.sv
src/extract_control.sv
src/config_controls.sv
src/stream_flow_control.sv
src/leaf_interface.sv
tb/clk_gen.sv
tb/leaf_props.sv
tb/leaf_tb.sv

//--- Makefile
# Verilator build and run of the leaf interface testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		--top-module leaf_tb -f sim.f -o leaf_sim
	./obj_dir/leaf_sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
